//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

  localparam int instrWidth = 32;

  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;

  localparam opcodeT opRType     = 6'd0;
  localparam opcodeT opJump      = 6'd2;
  localparam opcodeT opBeq       = 6'd4;
  localparam opcodeT opBne       = 6'd5;
  localparam opcodeT opLoadWord  = 6'd35;
  localparam opcodeT opStoreWord = 6'd43;

  localparam functT functNop   = 6'd0;
  localparam functT functBreak = 6'd13;

  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } rFieldsT;

  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [instrWidth-$bits(opcodeT)-11:0] immediate; // rest of the word, 16 bits
  } iFieldsT;

  // one instruction register word, two readings
  typedef union packed {
    rFieldsT rFields;
    iFieldsT iFields;
  } instrWordT;

  typedef enum logic [3:0] {
    classRType,
    classNop,
    classHalt,
    classLoad,
    classStore,
    classBeq,
    classBne,
    classJump,
    classUnknown
  } instrClassT;

endpackage

`default_nettype wire

//--- rtl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  typedef enum logic [4:0] {
    fetchIssue,
    fetchWait,
    fetchPcLoad,
    irLoad,
    decode,
    lwOperand,
    lwAddress,
    lwRead,
    lwWait1,
    lwWait2,
    lwMdrLoad,
    lwWriteBack,
    swOperand,
    swAddress,
    swWrite,
    rOperand,
    rExecute,
    rWriteBack,
    beqOffset,
    beqTarget,
    beqOperand,
    beqResolve,
    bneOffset,
    bneTarget,
    bneOperand,
    bneResolve,
    halt
  } stateT;

  typedef enum logic [1:0] {
    aluAdd   = 2'd0,
    aluSub   = 2'd1,
    aluFunct = 2'd2, // alu control reads funct
    aluIdle  = 2'd3
  } aluOpT;

  typedef enum logic [1:0] {
    srcBRegB      = 2'd0,
    srcBFour      = 2'd1,
    srcBSignExt   = 2'd2,
    srcBBranchOff = 2'd3  // sign extended, shifted by two
  } aluSrcBT;

  typedef enum logic [1:0] {
    pcFromAlu    = 2'd0,
    pcFromAluOut = 2'd1,
    pcFromJump   = 2'd2
  } pcSourceT;

endpackage

`default_nettype wire

//--- rtl/opcodeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder (
  input  isaPkg::instrWordT  instr,
  output isaPkg::instrClassT instrClass
);

  isaPkg::opcodeT opcode;
  isaPkg::functT  funct;

  assign opcode = instr.iFields.opcode;
  assign funct  = instr.rFields.funct; // only meaningful for opRType

  always_comb begin
    case (opcode)
      isaPkg::opRType: begin
        case (funct)
          isaPkg::functNop:   instrClass = isaPkg::classNop;
          isaPkg::functBreak: instrClass = isaPkg::classHalt;
          default:            instrClass = isaPkg::classRType;
        endcase
      end
      isaPkg::opJump: begin
        instrClass = isaPkg::classJump;
      end
      isaPkg::opBeq: begin
        instrClass = isaPkg::classBeq;
      end
      isaPkg::opBne: begin
        instrClass = isaPkg::classBne;
      end
      isaPkg::opLoadWord: begin
        instrClass = isaPkg::classLoad;
      end
      isaPkg::opStoreWord: begin
        instrClass = isaPkg::classStore;
      end
      default: begin
        instrClass = isaPkg::classUnknown; // back to fetch
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/stateSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
  input  logic               Clock,
  input  logic               arstN,
  input  isaPkg::instrClassT instrClass,
  output ctrlPkg::stateT     state
);

  ctrlPkg::stateT nextState;

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      state <= ctrlPkg::fetchIssue;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = ctrlPkg::fetchIssue;
    case (state)
      ctrlPkg::fetchIssue:  nextState = ctrlPkg::fetchWait;
      ctrlPkg::fetchWait:   nextState = ctrlPkg::fetchPcLoad;
      ctrlPkg::fetchPcLoad: nextState = ctrlPkg::irLoad;
      ctrlPkg::irLoad:      nextState = ctrlPkg::decode;

      ctrlPkg::decode: begin
        case (instrClass)
          isaPkg::classRType: nextState = ctrlPkg::rOperand;
          isaPkg::classLoad:  nextState = ctrlPkg::lwOperand;
          isaPkg::classStore: nextState = ctrlPkg::swOperand;
          isaPkg::classBeq:   nextState = ctrlPkg::beqOffset;
          isaPkg::classBne:   nextState = ctrlPkg::bneOffset;
          isaPkg::classHalt:  nextState = ctrlPkg::halt;
          default:            nextState = ctrlPkg::fetchIssue; // jump, nop, unknown
        endcase
      end

      ctrlPkg::lwOperand:   nextState = ctrlPkg::lwAddress;
      ctrlPkg::lwAddress:   nextState = ctrlPkg::lwRead;
      ctrlPkg::lwRead:      nextState = ctrlPkg::lwWait1;
      ctrlPkg::lwWait1:     nextState = ctrlPkg::lwWait2;
      ctrlPkg::lwWait2:     nextState = ctrlPkg::lwMdrLoad; // memory has answered
      ctrlPkg::lwMdrLoad:   nextState = ctrlPkg::lwWriteBack;
      ctrlPkg::lwWriteBack: nextState = ctrlPkg::fetchIssue;

      ctrlPkg::swOperand:   nextState = ctrlPkg::swAddress;
      ctrlPkg::swAddress:   nextState = ctrlPkg::swWrite;
      ctrlPkg::swWrite:     nextState = ctrlPkg::fetchIssue;

      ctrlPkg::rOperand:    nextState = ctrlPkg::rExecute;
      ctrlPkg::rExecute:    nextState = ctrlPkg::rWriteBack;
      ctrlPkg::rWriteBack:  nextState = ctrlPkg::fetchIssue;

      ctrlPkg::beqOffset:   nextState = ctrlPkg::beqTarget;
      ctrlPkg::beqTarget:   nextState = ctrlPkg::beqOperand;
      ctrlPkg::beqOperand:  nextState = ctrlPkg::beqResolve;
      ctrlPkg::beqResolve:  nextState = ctrlPkg::fetchIssue;

      ctrlPkg::bneOffset:   nextState = ctrlPkg::bneTarget;
      ctrlPkg::bneTarget:   nextState = ctrlPkg::bneOperand;
      ctrlPkg::bneOperand:  nextState = ctrlPkg::bneResolve;
      ctrlPkg::bneResolve:  nextState = ctrlPkg::fetchIssue;

      ctrlPkg::halt:        nextState = ctrlPkg::halt; // left only by reset

      default:              nextState = ctrlPkg::fetchIssue;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/controlOutputs.sv
`timescale 1ns/1ps
`default_nettype none

module controlOutputs (
  input  ctrlPkg::stateT     state,
  input  isaPkg::instrClassT instrClass,
  output logic               pcWrite,
  output logic               memWrite,
  output logic               irWrite,
  output logic               regWrite,
  output logic               regDst,
  output logic               aluSrcA,
  output logic               memToReg,
  output logic               iOrD,
  output logic               regALoad,
  output logic               regBLoad,
  output logic               aluOutLoad,
  output logic               mdrLoad,
  output logic               pcWriteCond,
  output logic               pcWriteCondNe,
  output ctrlPkg::aluOpT     aluOp,
  output ctrlPkg::aluSrcBT   aluSrcB,
  output ctrlPkg::pcSourceT  pcSource
);

  always_comb begin
    pcWrite       = 1'b0;
    memWrite      = 1'b0;
    irWrite       = 1'b0;
    regWrite      = 1'b0;
    regDst        = 1'b0;
    aluSrcA       = 1'b0;
    memToReg      = 1'b0;
    iOrD          = 1'b0;
    regALoad      = 1'b0;
    regBLoad      = 1'b0;
    aluOutLoad    = 1'b0;
    mdrLoad       = 1'b0;
    pcWriteCond   = 1'b0;
    pcWriteCondNe = 1'b0;
    aluOp         = ctrlPkg::aluIdle;
    aluSrcB       = ctrlPkg::srcBRegB;
    pcSource      = ctrlPkg::pcFromAlu;

    case (state)
      ctrlPkg::fetchIssue: begin
        aluOp      = ctrlPkg::aluAdd; // pc + 4
        aluSrcB    = ctrlPkg::srcBFour;
        aluOutLoad = 1'b1;
      end
      ctrlPkg::fetchPcLoad: begin
        aluOp   = ctrlPkg::aluAdd;
        aluSrcB = ctrlPkg::srcBFour;
        pcWrite = 1'b1;
      end
      ctrlPkg::irLoad: begin
        irWrite = 1'b1;
      end
      ctrlPkg::decode: begin
        if (instrClass == isaPkg::classJump) begin
          pcWrite  = 1'b1;
          pcSource = ctrlPkg::pcFromJump;
        end else if (instrClass == isaPkg::classBeq || instrClass == isaPkg::classBne) begin
          aluSrcB = ctrlPkg::srcBBranchOff;
        end
      end
      ctrlPkg::lwOperand, ctrlPkg::swOperand: begin
        regALoad = 1'b1;
        regBLoad = 1'b1;
      end
      ctrlPkg::lwAddress, ctrlPkg::swAddress: begin
        aluOp      = ctrlPkg::aluAdd; // base + offset
        aluSrcA    = 1'b1;
        aluSrcB    = ctrlPkg::srcBSignExt;
        aluOutLoad = 1'b1;
      end
      ctrlPkg::lwRead, ctrlPkg::lwWait1, ctrlPkg::lwWait2: begin
        iOrD = 1'b1;
      end
      ctrlPkg::lwMdrLoad: begin
        mdrLoad = 1'b1;
      end
      ctrlPkg::lwWriteBack: begin
        regWrite = 1'b1;
        memToReg = 1'b1;
      end
      ctrlPkg::swWrite: begin
        aluOp      = ctrlPkg::aluAdd; // address held steady during the write
        aluSrcA    = 1'b1;
        aluSrcB    = ctrlPkg::srcBSignExt;
        aluOutLoad = 1'b1;
        memWrite   = 1'b1;
        iOrD       = 1'b1;
      end
      ctrlPkg::rOperand: begin
        regDst   = 1'b1;
        regALoad = 1'b1;
        regBLoad = 1'b1;
      end
      ctrlPkg::rExecute, ctrlPkg::rWriteBack: begin
        regDst     = 1'b1;
        aluSrcA    = 1'b1;
        aluOp      = ctrlPkg::aluFunct;
        regALoad   = 1'b1;
        regBLoad   = 1'b1;
        aluOutLoad = 1'b1;
        regWrite   = (state == ctrlPkg::rWriteBack);
      end
      ctrlPkg::beqOffset, ctrlPkg::bneOffset: begin
        aluOp   = ctrlPkg::aluAdd;
        aluSrcB = ctrlPkg::srcBBranchOff;
      end
      ctrlPkg::beqTarget, ctrlPkg::bneTarget: begin
        aluOp      = ctrlPkg::aluAdd; // branch target into aluOut
        aluSrcB    = ctrlPkg::srcBBranchOff;
        aluOutLoad = 1'b1;
      end
      ctrlPkg::beqOperand, ctrlPkg::bneOperand: begin
        aluOp    = ctrlPkg::aluAdd;
        aluSrcB  = ctrlPkg::srcBFour;
        regALoad = 1'b1;
        regBLoad = 1'b1;
      end
      ctrlPkg::beqResolve, ctrlPkg::bneResolve: begin
        aluOp         = ctrlPkg::aluSub; // zero flag decides
        aluSrcA       = 1'b1;
        pcSource      = ctrlPkg::pcFromAluOut;
        pcWriteCond   = (state == ctrlPkg::beqResolve);
        pcWriteCondNe = (state == ctrlPkg::bneResolve);
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  logic              Clock,
  input  logic              arstN,
  input  isaPkg::instrWordT instr,
  output ctrlPkg::stateT    state,
  output logic              pcWrite,
  output logic              memWrite,
  output logic              irWrite,
  output logic              regWrite,
  output logic              regDst,
  output logic              aluSrcA,
  output logic              memToReg,
  output logic              iOrD,
  output logic              regALoad,
  output logic              regBLoad,
  output logic              aluOutLoad,
  output logic              mdrLoad,
  output logic              pcWriteCond,
  output logic              pcWriteCondNe,
  output ctrlPkg::aluOpT    aluOp,
  output ctrlPkg::aluSrcBT  aluSrcB,
  output ctrlPkg::pcSourceT pcSource
);

  isaPkg::instrClassT instrClass; // valid while state is decode

  opcodeDecoder decoder0 (
    .instr      (instr),
    .instrClass (instrClass)
  );

  stateSequencer sequencer0 (
    .Clock      (Clock),
    .arstN      (arstN),
    .instrClass (instrClass),
    .state      (state)
  );

  controlOutputs outputs0 (
    .state         (state),
    .instrClass    (instrClass),
    .pcWrite       (pcWrite),
    .memWrite      (memWrite),
    .irWrite       (irWrite),
    .regWrite      (regWrite),
    .regDst        (regDst),
    .aluSrcA       (aluSrcA),
    .memToReg      (memToReg),
    .iOrD          (iOrD),
    .regALoad      (regALoad),
    .regBLoad      (regBLoad),
    .aluOutLoad    (aluOutLoad),
    .mdrLoad       (mdrLoad),
    .pcWriteCond   (pcWriteCond),
    .pcWriteCondNe (pcWriteCondNe),
    .aluOp         (aluOp),
    .aluSrcB       (aluSrcB),
    .pcSource      (pcSource)
  );

endmodule

`default_nettype wire

//--- tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic Clock,
  output logic arstN
);

  localparam int halfPeriodNs = 2; // 4 ns period
  localparam int resetCycles  = 8;

  initial begin
    Clock = 1'b0;
    forever #(halfPeriodNs) Clock = ~Clock;
  end

  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge Clock);
    @(negedge Clock); // release away from the sampling edge
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/controlChecker.sv
`timescale 1ns/1ps
`default_nettype none

module controlChecker (
  input  logic              Clock,
  input  logic              arstN,
  input  isaPkg::instrWordT instr,
  input  ctrlPkg::stateT    state,
  input  logic              pcWrite,
  input  logic              memWrite,
  input  logic              irWrite,
  input  logic              regWrite,
  input  logic              regDst,
  input  logic              aluSrcA,
  input  logic              memToReg,
  input  logic              iOrD,
  input  logic              regALoad,
  input  logic              regBLoad,
  input  logic              aluOutLoad,
  input  logic              mdrLoad,
  input  logic              pcWriteCond,
  input  logic              pcWriteCondNe,
  input  ctrlPkg::aluOpT    aluOp,
  input  ctrlPkg::aluSrcBT  aluSrcB,
  input  ctrlPkg::pcSourceT pcSource,
  output int                stateErrors,
  output int                outputErrors,
  output int                cycleErrors,
  output int                checkCount
);

  typedef struct packed {
    logic              pcWrite;
    logic              memWrite;
    logic              irWrite;
    logic              regWrite;
    logic              regDst;
    logic              aluSrcA;
    logic              memToReg;
    logic              iOrD;
    logic              regALoad;
    logic              regBLoad;
    logic              aluOutLoad;
    logic              mdrLoad;
    logic              pcWriteCond;
    logic              pcWriteCondNe;
    ctrlPkg::aluOpT    aluOp;
    ctrlPkg::aluSrcBT  aluSrcB;
    ctrlPkg::pcSourceT pcSource;
  } ctrlOutT;

  ctrlOutT            actual;
  ctrlOutT            expOut;
  ctrlPkg::stateT     expState;
  isaPkg::instrClassT cls;
  isaPkg::instrClassT seenClass;
  logic               instrSeen;
  int                 cycleCount;

  assign actual = {pcWrite, memWrite, irWrite, regWrite, regDst, aluSrcA, memToReg, iOrD,
                   regALoad, regBLoad, aluOutLoad, mdrLoad, pcWriteCond, pcWriteCondNe,
                   aluOp, aluSrcB, pcSource};

  function automatic isaPkg::instrClassT classify(input logic [31:0] word);
    if (word[31:26] == isaPkg::opRType) begin
      if (word[5:0] == isaPkg::functNop) return isaPkg::classNop;
      if (word[5:0] == isaPkg::functBreak) return isaPkg::classHalt;
      return isaPkg::classRType;
    end
    case (word[31:26])
      isaPkg::opJump:      return isaPkg::classJump;
      isaPkg::opBeq:       return isaPkg::classBeq;
      isaPkg::opBne:       return isaPkg::classBne;
      isaPkg::opLoadWord:  return isaPkg::classLoad;
      isaPkg::opStoreWord: return isaPkg::classStore;
      default:             return isaPkg::classUnknown;
    endcase
  endfunction

  function automatic ctrlOutT expectedOutputs(input ctrlPkg::stateT s,
                                              input isaPkg::instrClassT c);
    ctrlOutT e;
    e = '0;
    e.aluOp = ctrlPkg::aluIdle;
    case (s)
      ctrlPkg::fetchIssue, ctrlPkg::fetchPcLoad: begin
        e.aluOp      = ctrlPkg::aluAdd;
        e.aluSrcB    = ctrlPkg::srcBFour;
        e.aluOutLoad = (s == ctrlPkg::fetchIssue);
        e.pcWrite    = (s == ctrlPkg::fetchPcLoad);
      end
      ctrlPkg::irLoad: e.irWrite = 1'b1;
      ctrlPkg::decode: begin
        if (c == isaPkg::classJump) begin
          e.pcWrite  = 1'b1;
          e.pcSource = ctrlPkg::pcFromJump;
        end
        if (c == isaPkg::classBeq || c == isaPkg::classBne) e.aluSrcB = ctrlPkg::srcBBranchOff;
      end
      ctrlPkg::lwOperand, ctrlPkg::swOperand, ctrlPkg::rOperand: begin
        e.regALoad = 1'b1;
        e.regBLoad = 1'b1;
        e.regDst   = (s == ctrlPkg::rOperand);
      end
      ctrlPkg::lwAddress, ctrlPkg::swAddress, ctrlPkg::swWrite: begin
        e.aluOp      = ctrlPkg::aluAdd;
        e.aluSrcA    = 1'b1;
        e.aluSrcB    = ctrlPkg::srcBSignExt;
        e.aluOutLoad = 1'b1;
        e.memWrite   = (s == ctrlPkg::swWrite);
        e.iOrD       = (s == ctrlPkg::swWrite);
      end
      ctrlPkg::lwRead, ctrlPkg::lwWait1, ctrlPkg::lwWait2: e.iOrD = 1'b1;
      ctrlPkg::lwMdrLoad: e.mdrLoad = 1'b1;
      ctrlPkg::lwWriteBack: begin
        e.regWrite = 1'b1;
        e.memToReg = 1'b1;
      end
      ctrlPkg::rExecute, ctrlPkg::rWriteBack: begin
        e.regDst     = 1'b1;
        e.aluSrcA    = 1'b1;
        e.aluOp      = ctrlPkg::aluFunct;
        e.regALoad   = 1'b1;
        e.regBLoad   = 1'b1;
        e.aluOutLoad = 1'b1;
        e.regWrite   = (s == ctrlPkg::rWriteBack);
      end
      ctrlPkg::beqOffset, ctrlPkg::bneOffset, ctrlPkg::beqTarget, ctrlPkg::bneTarget: begin
        e.aluOp      = ctrlPkg::aluAdd;
        e.aluSrcB    = ctrlPkg::srcBBranchOff;
        e.aluOutLoad = (s == ctrlPkg::beqTarget || s == ctrlPkg::bneTarget);
      end
      ctrlPkg::beqOperand, ctrlPkg::bneOperand: begin
        e.aluOp    = ctrlPkg::aluAdd;
        e.aluSrcB  = ctrlPkg::srcBFour;
        e.regALoad = 1'b1;
        e.regBLoad = 1'b1;
      end
      ctrlPkg::beqResolve, ctrlPkg::bneResolve: begin
        e.aluOp         = ctrlPkg::aluSub;
        e.aluSrcA       = 1'b1;
        e.pcSource      = ctrlPkg::pcFromAluOut;
        e.pcWriteCond   = (s == ctrlPkg::beqResolve);
        e.pcWriteCondNe = (s == ctrlPkg::bneResolve);
      end
      default: e.aluOp = ctrlPkg::aluIdle; // halt keeps defaults
    endcase
    return e;
  endfunction

  function automatic ctrlPkg::stateT followingState(input ctrlPkg::stateT s,
                                                    input isaPkg::instrClassT c);
    case (s)
      ctrlPkg::decode: begin
        case (c)
          isaPkg::classRType: return ctrlPkg::rOperand;
          isaPkg::classLoad:  return ctrlPkg::lwOperand;
          isaPkg::classStore: return ctrlPkg::swOperand;
          isaPkg::classBeq:   return ctrlPkg::beqOffset;
          isaPkg::classBne:   return ctrlPkg::bneOffset;
          isaPkg::classHalt:  return ctrlPkg::halt;
          default:            return ctrlPkg::fetchIssue;
        endcase
      end
      ctrlPkg::lwWriteBack, ctrlPkg::swWrite, ctrlPkg::rWriteBack,
      ctrlPkg::beqResolve, ctrlPkg::bneResolve: return ctrlPkg::fetchIssue;
      ctrlPkg::halt: return ctrlPkg::halt;
      default: return s.next(); // chains run in listed order
    endcase
  endfunction

  function automatic int expectedCycles(input isaPkg::instrClassT c);
    case (c)
      isaPkg::classStore, isaPkg::classRType: return 8;
      isaPkg::classBeq, isaPkg::classBne:     return 9;
      isaPkg::classLoad:                      return 12;
      default:                                return 5;
    endcase
  endfunction

  always @(posedge Clock) begin
    if (!arstN) begin
      expState     = ctrlPkg::fetchIssue;
      instrSeen    = 1'b0;
      cycleCount   = 0;
      stateErrors  = 0;
      outputErrors = 0;
      cycleErrors  = 0;
      checkCount   = 0;
    end else begin
      cls = classify(instr);
      expOut = expectedOutputs(expState, cls);
      checkCount++;
      if (state !== expState) begin
        stateErrors++;
        $display("Fail state: expected %s, actual %s", expState.name(), state.name());
      end
      if (actual !== expOut) begin
        outputErrors++;
        $display("Fail outputs in %s: expected %h, actual %h", expState.name(), expOut, actual);
      end
      if (state == ctrlPkg::fetchIssue) begin
        if (instrSeen && cycleCount != expectedCycles(seenClass)) begin
          cycleErrors++;
          $display("Fail cycles of %s: expected %0d, actual %0d", seenClass.name(),
                   expectedCycles(seenClass), cycleCount);
        end
        cycleCount = 0;
      end
      cycleCount++;
      if (expState == ctrlPkg::decode) begin
        seenClass = cls;
        instrSeen = 1'b1;
      end
      expState = followingState(expState, cls);
    end
  end

endmodule

`default_nettype wire

//--- tb/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

  localparam int periodNs   = 4;
  localparam int wordCount  = 60;
  localparam int haltCycles = 20;
  localparam int timeoutNs  = (8 + wordCount * 12 + 100) * periodNs;

  logic               Clock;
  logic               arstN;
  isaPkg::instrWordT  instr;
  ctrlPkg::stateT     state;
  logic               pcWrite, memWrite, irWrite, regWrite, regDst, aluSrcA, memToReg;
  logic               iOrD, regALoad, regBLoad, aluOutLoad, mdrLoad, pcWriteCond, pcWriteCondNe;
  ctrlPkg::aluOpT     aluOp;
  ctrlPkg::aluSrcBT   aluSrcB;
  ctrlPkg::pcSourceT  pcSource;
  int                 stateErrors, outputErrors, cycleErrors, checkCount;

  isaPkg::instrWordT  wordList[$];
  int                 nextIdx;

  clockGen clockGen0 (.Clock(Clock), .arstN(arstN));

  controlUnit dut0 (.*);

  controlChecker checker0 (.*);

  function automatic isaPkg::instrWordT makeWord(input isaPkg::instrClassT cls);
    isaPkg::instrWordT w;
    isaPkg::functT     fn;
    isaPkg::opcodeT    op;
    w = $urandom; // random register and immediate fields
    if (cls == isaPkg::classRType || cls == isaPkg::classNop || cls == isaPkg::classHalt) begin
      fn = 6'($urandom_range(1, 63));
      if (fn == isaPkg::functBreak) fn = fn + 6'd1;
      if (cls == isaPkg::classNop) fn = isaPkg::functNop;
      if (cls == isaPkg::classHalt) fn = isaPkg::functBreak;
      if ($urandom_range(0, 1) == 1) begin
        w.rFields.opcode = isaPkg::opRType;
        w.rFields.funct  = fn;
      end else begin
        w.iFields.opcode         = isaPkg::opRType; // same word through the I view
        w.iFields.immediate[5:0] = fn;
      end
      return w;
    end
    case (cls)
      isaPkg::classJump:  op = isaPkg::opJump;
      isaPkg::classBeq:   op = isaPkg::opBeq;
      isaPkg::classBne:   op = isaPkg::opBne;
      isaPkg::classLoad:  op = isaPkg::opLoadWord;
      isaPkg::classStore: op = isaPkg::opStoreWord;
      default: begin
        op = isaPkg::opRType;
        while (op == isaPkg::opRType || op == isaPkg::opJump || op == isaPkg::opBeq ||
               op == isaPkg::opBne || op == isaPkg::opLoadWord || op == isaPkg::opStoreWord) begin
          op = 6'($urandom_range(0, 63)); // only unassigned codes
        end
      end
    endcase
    w.iFields.opcode = op;
    return w;
  endfunction

  task automatic reportCounts();
    $display("errors: state %0d, outputs %0d, cycles %0d, over %0d checks",
             stateErrors, outputErrors, cycleErrors, checkCount);
  endtask

  initial begin
    isaPkg::instrClassT cls;
    instr = '0;
    void'($urandom(32'hdef8_0020));
    for (int i = 0; i < wordCount; i++) begin
      cls = isaPkg::classHalt;
      while (cls == isaPkg::classHalt) begin
        cls = isaPkg::instrClassT'($urandom_range(0, 8));
      end
      wordList.push_back(makeWord(cls));
    end
    wordList.push_back(makeWord(isaPkg::classHalt));

    nextIdx = 0;
    while (nextIdx < wordList.size()) begin
      @(negedge Clock);
      if (irWrite) begin
        instr = wordList[nextIdx]; // instruction register takes the next word
        nextIdx++;
      end
    end
    while (state != ctrlPkg::halt) @(negedge Clock);
    repeat (haltCycles) @(negedge Clock);

    reportCounts();
    if (stateErrors + outputErrors + cycleErrors == 0 && checkCount > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(timeoutNs);
    $display("The run timed out before the final break halted the control unit.");
    reportCounts();
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- controlUnit.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/opcodeDecoder.sv
rtl/stateSequencer.sv
rtl/controlOutputs.sv
rtl/controlUnit.sv
tb/clockGen.sv
tb/controlChecker.sv
tb/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the control unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -j 0 \
  --top-module controlUnitTb \
  --Mdir "$buildDir" \
  -o controlUnitSim \
  -f controlUnit.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$buildDir/controlUnitSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1
